// ==== src/distribute_pkg.sv ====
// lane distributor shared definitions
// lane and bus widths, fifo sizing, sequencer config and state
// used by both the input and the output path

package distribute_pkg;

  localparam int num_lanes      = 4;                       // lanes per path
  localparam int group_size     = 4;                       // items per lane word
  localparam int data_width     = 8;                       // bits per item
  localparam int lane_width     = group_size * data_width; // 32 bit lane word
  localparam int iter_width     = 16;                      // iteration counter
  localparam int reads_width    = 16;                      // reads per iteration counter
  localparam int fifo_depth     = 4;                       // slots per lane fifo
  localparam int fifo_ptr_width = 2;                       // log2 of fifo_depth

  // one lane word, group_size items packed
  typedef logic [lane_width-1:0] lane_t;

  // all lanes side by side, lane 0 in the low bits
  typedef lane_t [num_lanes-1:0] lane_bus_t;

  // one weight item per output lane
  typedef logic [num_lanes-1:0][data_width-1:0] weight_t;

  // run configuration, sampled on the configure pulse
  typedef struct packed {
    logic [iter_width-1:0]  num_iters;  // iterations, never zero
    logic [reads_width-1:0] num_reads;  // reads per iteration, never zero
  } seq_cfg_t;

  // sequencer state
  typedef enum logic {
    seq_idle = 1'b0,  // waiting for configure
    seq_run  = 1'b1   // counting reads
  } seq_state_e;

endpackage

// ==== src/lane_fifo.sv ====
// lane fifo
// show-ahead synchronous fifo, head word always on rd_data
// occupancy counter drives empty, full and almost_full
// avail upstream is taken from full and almost_full so that one
// write may still be in flight when the flag rises

`timescale 1ns/1ps

module lane_fifo #(
  parameter int width = 32  // word width
) (
  input  logic             clk,
  input  logic             rst,          // sync, active low
  input  logic [width-1:0] wr_data,
  input  logic             wr,           // push wr_data
  output logic             full,
  output logic             almost_full,  // one slot left
  output logic [width-1:0] rd_data,      // head word
  input  logic             rd,           // pop head
  output logic             empty
);

  logic [width-1:0] mem [distribute_pkg::fifo_depth];  // storage, no reset
  logic [distribute_pkg::fifo_ptr_width-1:0] wr_ptr;   // wraps at fifo_depth
  logic [distribute_pkg::fifo_ptr_width-1:0] rd_ptr;
  logic [distribute_pkg::fifo_ptr_width:0]   count;    // 0..fifo_depth
  logic do_wr;
  logic do_rd;

  assign do_wr = wr & ~full;   // guarded, protocol keeps this true anyway
  assign do_rd = rd & ~empty;

  // flags straight from occupancy
  assign empty       = (count == '0);
  assign full        = (count == (distribute_pkg::fifo_ptr_width+1)'(distribute_pkg::fifo_depth));
  assign almost_full = (count == (distribute_pkg::fifo_ptr_width+1)'(distribute_pkg::fifo_depth-1));

  assign rd_data = mem[rd_ptr];  // show-ahead

  // payload write
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // natural wrap
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // both or neither
      endcase
    end
  end

  // upstream must respect avail
  a_no_wr_full: assert property (@(posedge clk) disable iff (!rst) wr |-> !full)
    else $error("lane_fifo write while full");

  // parent only pops lanes it saw non-empty
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst) rd |-> !empty)
    else $error("lane_fifo read while empty");

endmodule

// ==== src/read_sequencer.sv ====
// read sequencer
// counts performed reads per iteration and iterations per run
// configure loads a new run and overrides any run in progress
// first_read marks the first read of every iteration
// state moves one edge after the read strobe

`timescale 1ns/1ps

module read_sequencer (
  input  logic                     clk,
  input  logic                     rst,         // sync, active low
  input  logic                     configure,   // load cfg, start run
  input  distribute_pkg::seq_cfg_t cfg,
  input  logic                     read,        // performed read from parent
  output logic                     busy,        // run in progress
  output logic                     first_read   // reads counter still at its copy
);

  distribute_pkg::seq_state_e state_q;
  logic [distribute_pkg::reads_width-1:0] reads_q;       // down counter
  logic [distribute_pkg::reads_width-1:0] reads_copy_q;  // reload value
  logic [distribute_pkg::iter_width-1:0]  iters_q;       // iterations left
  logic last_read;
  logic last_iter;

  assign last_read = (reads_q == (distribute_pkg::reads_width)'(1));
  assign last_iter = (iters_q == (distribute_pkg::iter_width)'(1));

  assign busy       = (state_q == distribute_pkg::seq_run);
  assign first_read = busy & (reads_q == reads_copy_q);

  // reload copy, only meaningful while busy
  always_ff @(posedge clk) begin
    if (configure) begin
      reads_copy_q <= cfg.num_reads;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= distribute_pkg::seq_idle;
      reads_q <= '0;
      iters_q <= '0;
    end else if (configure) begin
      // new run wins over anything in flight
      state_q <= distribute_pkg::seq_run;
      reads_q <= cfg.num_reads;
      iters_q <= cfg.num_iters;
    end else if (read) begin
      if (last_read) begin
        reads_q <= reads_copy_q;               // next iteration
        if (last_iter) begin
          state_q <= distribute_pkg::seq_idle; // run done
        end else begin
          iters_q <= iters_q - 1'b1;
        end
      end else begin
        reads_q <= reads_q - 1'b1;
      end
    end
  end

  // parent gates its strobe with busy
  a_no_read_idle: assert property (@(posedge clk) disable iff (!rst)
    read |-> (state_q == distribute_pkg::seq_run))
    else $error("read strobe while sequencer idle");

  // zero counts would never terminate
  a_cfg_nonzero: assert property (@(posedge clk) disable iff (!rst)
    configure |-> (cfg.num_iters != '0) && (cfg.num_reads != '0))
    else $error("configure with zero iterations or reads");

endmodule

// ==== src/distribute_in.sv ====
// distribute_in
// input path of the lane distributor
// one fifo per activation lane plus one weight fifo
// a read sends all activation lanes out, weights only on the
// first read of each iteration
// read needs busy, every lane non-empty and every output avail

`timescale 1ns/1ps

module distribute_in (
  input  logic                                 clk,
  input  logic                                 rst,            // sync, active low
  input  logic                                 configure,
  input  distribute_pkg::seq_cfg_t             cfg,
  input  distribute_pkg::lane_bus_t            act_data,       // activation lanes in
  input  logic [distribute_pkg::num_lanes-1:0] act_valid,
  output logic [distribute_pkg::num_lanes-1:0] act_avail,
  input  distribute_pkg::weight_t              wgt_data,       // weight word in
  input  logic                                 wgt_valid,
  output logic                                 wgt_avail,
  output distribute_pkg::lane_bus_t            act_out,        // activation lanes out
  output logic                                 act_out_valid,  // one bit for all lanes
  input  logic [distribute_pkg::num_lanes-1:0] act_out_avail,
  output distribute_pkg::weight_t              wgt_out,
  output logic                                 wgt_out_valid,
  input  logic                                 wgt_out_avail,
  output logic                                 busy
);

  logic [distribute_pkg::num_lanes-1:0] act_full;
  logic [distribute_pkg::num_lanes-1:0] act_afull;
  logic [distribute_pkg::num_lanes-1:0] act_empty;
  logic wgt_full;
  logic wgt_afull;
  logic wgt_empty;
  logic first_read;
  logic wgt_ok;      // weight side ready, or not needed
  logic read;        // performed read this cycle

  // weights only matter on a first read
  assign wgt_ok = ~first_read | (~wgt_empty & wgt_out_avail);
  assign read   = busy & ~(|act_empty) & (&act_out_avail) & wgt_ok;

  assign act_out_valid = read;
  assign wgt_out_valid = read & first_read;

  // activation lanes, pop all on every read
  for (genvar i = 0; i < distribute_pkg::num_lanes; i++) begin : g_act
    assign act_avail[i] = ~act_full[i] & ~act_afull[i];  // room for one in flight
    lane_fifo #(
      .width       (distribute_pkg::lane_width)
    ) act_fifo_inst (
      .clk         (clk),
      .rst         (rst),
      .wr_data     (act_data[i]),
      .wr          (act_valid[i]),
      .full        (act_full[i]),
      .almost_full (act_afull[i]),
      .rd_data     (act_out[i]),   // lane i straight to output i
      .rd          (read),
      .empty       (act_empty[i])
    );
  end

  assign wgt_avail = ~wgt_full & ~wgt_afull;

  // single weight fifo, popped on first reads only
  lane_fifo #(
    .width       ($bits(distribute_pkg::weight_t))
  ) wgt_fifo_inst (
    .clk         (clk),
    .rst         (rst),
    .wr_data     (wgt_data),
    .wr          (wgt_valid),
    .full        (wgt_full),
    .almost_full (wgt_afull),
    .rd_data     (wgt_out),
    .rd          (wgt_out_valid),
    .empty       (wgt_empty)
  );

  read_sequencer seq_inst (
    .clk        (clk),
    .rst        (rst),
    .configure  (configure),
    .cfg        (cfg),
    .read       (read),
    .busy       (busy),
    .first_read (first_read)
  );

  // run only ends on the last performed read
  a_busy_fall: assert property (@(posedge clk) disable iff (!rst)
    $fell(busy) |-> $past(act_out_valid))
    else $error("distribute_in busy fell without a read");

endmodule

// ==== src/distribute_out.sv ====
// distribute_out
// output path of the lane distributor
// one fifo per result lane, lane i forwarded to output i
// read needs busy, every lane non-empty and every output avail

`timescale 1ns/1ps

module distribute_out (
  input  logic                                 clk,
  input  logic                                 rst,            // sync, active low
  input  logic                                 configure,
  input  distribute_pkg::seq_cfg_t             cfg,
  input  distribute_pkg::lane_bus_t            res_data,       // result lanes in
  input  logic [distribute_pkg::num_lanes-1:0] res_valid,
  output logic [distribute_pkg::num_lanes-1:0] res_avail,
  output distribute_pkg::lane_bus_t            res_out,        // result lanes out
  output logic                                 res_out_valid,  // one bit for all lanes
  input  logic [distribute_pkg::num_lanes-1:0] res_out_avail,
  output logic                                 busy
);

  logic [distribute_pkg::num_lanes-1:0] res_full;
  logic [distribute_pkg::num_lanes-1:0] res_afull;
  logic [distribute_pkg::num_lanes-1:0] res_empty;
  logic read;

  assign read          = busy & ~(|res_empty) & (&res_out_avail);
  assign res_out_valid = read;

  for (genvar i = 0; i < distribute_pkg::num_lanes; i++) begin : g_res
    assign res_avail[i] = ~res_full[i] & ~res_afull[i];
    lane_fifo #(
      .width       (distribute_pkg::lane_width)
    ) res_fifo_inst (
      .clk         (clk),
      .rst         (rst),
      .wr_data     (res_data[i]),
      .wr          (res_valid[i]),
      .full        (res_full[i]),
      .almost_full (res_afull[i]),
      .rd_data     (res_out[i]),   // straight forward
      .rd          (read),
      .empty       (res_empty[i])
    );
  end

  // every read alike here, no first read gating
  read_sequencer seq_inst (
    .clk        (clk),
    .rst        (rst),
    .configure  (configure),
    .cfg        (cfg),
    .read       (read),
    .busy       (busy),
    .first_read ()
  );

  // run only ends on the last performed read
  a_busy_fall: assert property (@(posedge clk) disable iff (!rst)
    $fell(busy) |-> $past(res_out_valid))
    else $error("distribute_out busy fell without a read");

endmodule

// ==== src/distribute_top.sv ====
// lane distributor top
// input path and output path side by side
// the two paths share clock and reset only, each has its own configure
// no logic here, instances only

`timescale 1ns/1ps

module distribute_top (
  input  logic                                 clk,
  input  logic                                 rst,               // sync, active low
  // input path
  input  logic                                 in_configure,
  input  distribute_pkg::seq_cfg_t             in_cfg,
  input  distribute_pkg::lane_bus_t            in_act_data,
  input  logic [distribute_pkg::num_lanes-1:0] in_act_valid,
  output logic [distribute_pkg::num_lanes-1:0] in_act_avail,
  input  distribute_pkg::weight_t              in_wgt_data,
  input  logic                                 in_wgt_valid,
  output logic                                 in_wgt_avail,
  output distribute_pkg::lane_bus_t            in_act_out,
  output logic                                 in_act_out_valid,
  input  logic [distribute_pkg::num_lanes-1:0] in_act_out_avail,
  output distribute_pkg::weight_t              in_wgt_out,
  output logic                                 in_wgt_out_valid,
  input  logic                                 in_wgt_out_avail,
  output logic                                 in_busy,
  // output path
  input  logic                                 out_configure,
  input  distribute_pkg::seq_cfg_t             out_cfg,
  input  distribute_pkg::lane_bus_t            out_res_data,
  input  logic [distribute_pkg::num_lanes-1:0] out_res_valid,
  output logic [distribute_pkg::num_lanes-1:0] out_res_avail,
  output distribute_pkg::lane_bus_t            out_res_out,
  output logic                                 out_res_out_valid,
  input  logic [distribute_pkg::num_lanes-1:0] out_res_out_avail,
  output logic                                 out_busy
);

  // activations and weights toward the array
  distribute_in distribute_in_inst (
    .clk           (clk),
    .rst           (rst),
    .configure     (in_configure),
    .cfg           (in_cfg),
    .act_data      (in_act_data),
    .act_valid     (in_act_valid),
    .act_avail     (in_act_avail),
    .wgt_data      (in_wgt_data),
    .wgt_valid     (in_wgt_valid),
    .wgt_avail     (in_wgt_avail),
    .act_out       (in_act_out),
    .act_out_valid (in_act_out_valid),
    .act_out_avail (in_act_out_avail),
    .wgt_out       (in_wgt_out),
    .wgt_out_valid (in_wgt_out_valid),
    .wgt_out_avail (in_wgt_out_avail),
    .busy          (in_busy)
  );

  // results back from the array
  distribute_out distribute_out_inst (
    .clk           (clk),
    .rst           (rst),
    .configure     (out_configure),
    .cfg           (out_cfg),
    .res_data      (out_res_data),
    .res_valid     (out_res_valid),
    .res_avail     (out_res_avail),
    .res_out       (out_res_out),
    .res_out_valid (out_res_out_valid),
    .res_out_avail (out_res_out_avail),
    .busy          (out_busy)
  );

endmodule

// ==== bench/tb_distribute_top.sv ====
// testbench for the lane distributor top
// random lane traffic into both paths, one scoreboard queue per lane
// concurrent assertions compare outputs with queue heads and flags

`timescale 1ns/1ps

module tb_distribute_top;

  typedef enum {
    until_in_idle,
    until_out_idle,
    until_lane0_full,
    until_lanes_full,
    until_wgt_full
  } wait_cond_e;

  localparam logic [13:0] idle_expect = 14'h01ff;  // busy, valids low, avails high

  logic clk;
  logic rst;
  logic                                 in_configure;
  distribute_pkg::seq_cfg_t             in_cfg;
  distribute_pkg::lane_bus_t            in_act_data;
  logic [distribute_pkg::num_lanes-1:0] in_act_valid;
  logic [distribute_pkg::num_lanes-1:0] in_act_avail;
  distribute_pkg::weight_t              in_wgt_data;
  logic                                 in_wgt_valid;
  logic                                 in_wgt_avail;
  distribute_pkg::lane_bus_t            in_act_out;
  logic                                 in_act_out_valid;
  logic [distribute_pkg::num_lanes-1:0] in_act_out_avail;
  distribute_pkg::weight_t              in_wgt_out;
  logic                                 in_wgt_out_valid;
  logic                                 in_wgt_out_avail;
  logic                                 in_busy;
  logic                                 out_configure;
  distribute_pkg::seq_cfg_t             out_cfg;
  distribute_pkg::lane_bus_t            out_res_data;
  logic [distribute_pkg::num_lanes-1:0] out_res_valid;
  logic [distribute_pkg::num_lanes-1:0] out_res_avail;
  distribute_pkg::lane_bus_t            out_res_out;
  logic                                 out_res_out_valid;
  logic [distribute_pkg::num_lanes-1:0] out_res_out_avail;
  logic                                 out_busy;

  string test_name;
  int    errors;
  logic [distribute_pkg::num_lanes-1:0] act_mask;  // lanes being fed
  logic [distribute_pkg::num_lanes-1:0] res_mask;
  logic wgt_feed;
  logic rand_in_avail;   // random downstream stalls, input path
  logic rand_out_avail;
  logic chk_reset;       // one cycle strobe for the idle check

  // scoreboard, accepted writes in order
  distribute_pkg::lane_t   act_q [distribute_pkg::num_lanes][$];
  distribute_pkg::lane_t   res_q [distribute_pkg::num_lanes][$];
  distribute_pkg::weight_t wgt_q [$];
  distribute_pkg::lane_t   exp_act [distribute_pkg::num_lanes];  // queue heads
  distribute_pkg::lane_t   exp_res [distribute_pkg::num_lanes];
  distribute_pkg::weight_t exp_wgt;
  int act_depth [distribute_pkg::num_lanes];  // expected fifo occupancy
  int res_depth [distribute_pkg::num_lanes];
  int wgt_depth;
  int in_seen;       // reads since last configure
  int in_total;      // iters times reads
  int in_reads_cfg;
  int out_seen;
  int out_total;
  int in_reads_all;  // whole run
  int out_reads_all;
  logic [13:0] idle_status;

  distribute_top distribute_top_inst (.*);

  assign idle_status = {in_busy, out_busy, in_act_out_valid, in_wgt_out_valid,
                        out_res_out_valid, in_act_avail, in_wgt_avail, out_res_avail};

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // monitor, pops before pushes so an empty lane never matches itself
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < distribute_pkg::num_lanes; i++) begin
        act_q[i].delete();
        res_q[i].delete();
      end
      wgt_q.delete();
      in_seen       <= 0;
      in_total      <= 0;
      in_reads_cfg  <= 1;
      out_seen      <= 0;
      out_total     <= 0;
      in_reads_all  <= 0;
      out_reads_all <= 0;
    end else begin
      for (int i = 0; i < distribute_pkg::num_lanes; i++) begin
        if (in_act_out_valid && act_q[i].size() > 0) void'(act_q[i].pop_front());
        if (out_res_out_valid && res_q[i].size() > 0) void'(res_q[i].pop_front());
        if (in_act_valid[i]) act_q[i].push_back(in_act_data[i]);
        if (out_res_valid[i]) res_q[i].push_back(out_res_data[i]);
      end
      if (in_wgt_out_valid && wgt_q.size() > 0) void'(wgt_q.pop_front());
      if (in_wgt_valid) wgt_q.push_back(in_wgt_data);
      if (in_configure) begin
        in_seen      <= 0;
        in_total     <= int'(in_cfg.num_iters) * int'(in_cfg.num_reads);
        in_reads_cfg <= int'(in_cfg.num_reads);
      end else if (in_act_out_valid) begin
        in_seen <= in_seen + 1;
      end
      if (out_configure) begin
        out_seen  <= 0;
        out_total <= int'(out_cfg.num_iters) * int'(out_cfg.num_reads);
      end else if (out_res_out_valid) begin
        out_seen <= out_seen + 1;
      end
      if (in_act_out_valid) in_reads_all <= in_reads_all + 1;
      if (out_res_out_valid) out_reads_all <= out_reads_all + 1;
    end
    for (int i = 0; i < distribute_pkg::num_lanes; i++) begin
      exp_act[i]   <= (act_q[i].size() > 0) ? act_q[i][0] : 'x;  // x never matches
      exp_res[i]   <= (res_q[i].size() > 0) ? res_q[i][0] : 'x;
      act_depth[i] <= act_q[i].size();
      res_depth[i] <= res_q[i].size();
    end
    exp_wgt   <= (wgt_q.size() > 0) ? wgt_q[0] : 'x;
    wgt_depth <= wgt_q.size();
  end

  a_reset: assert property (@(posedge clk) disable iff (!rst)
    chk_reset |-> idle_status == idle_expect)
    else begin
      errors++;
      $display("FAILED %s expected %h actual %h", test_name, idle_expect,
               $sampled(idle_status));
    end

  for (genvar i = 0; i < distribute_pkg::num_lanes; i++) begin : g_lane_chk
    a_act_head: assert property (@(posedge clk) disable iff (!rst)
      in_act_out_valid |-> in_act_out[i] === exp_act[i])
      else begin
        errors++;
        $display("FAILED %s act lane %0d expected %h actual %h", test_name, i,
                 $sampled(exp_act[i]), $sampled(in_act_out[i]));
      end
    a_res_head: assert property (@(posedge clk) disable iff (!rst)
      out_res_out_valid |-> out_res_out[i] === exp_res[i])
      else begin
        errors++;
        $display("FAILED %s res lane %0d expected %h actual %h", test_name, i,
                 $sampled(exp_res[i]), $sampled(out_res_out[i]));
      end
    // avail high only below fifo_depth minus 1 words
    a_act_avail: assert property (@(posedge clk) disable iff (!rst)
      in_act_avail[i] == (act_depth[i] < distribute_pkg::fifo_depth - 1))
      else begin
        errors++;
        $display("FAILED %s act_avail %0d expected %b actual %b", test_name, i,
                 $sampled(act_depth[i]) < 3, $sampled(in_act_avail[i]));
      end
    a_res_avail: assert property (@(posedge clk) disable iff (!rst)
      out_res_avail[i] == (res_depth[i] < distribute_pkg::fifo_depth - 1))
      else begin
        errors++;
        $display("FAILED %s res_avail %0d expected %b actual %b", test_name, i,
                 $sampled(res_depth[i]) < 3, $sampled(out_res_avail[i]));
      end
  end

  a_wgt_head: assert property (@(posedge clk) disable iff (!rst)
    in_wgt_out_valid |-> in_wgt_out === exp_wgt)
    else begin
      errors++;
      $display("FAILED %s wgt_out expected %h actual %h", test_name,
               $sampled(exp_wgt), $sampled(in_wgt_out));
    end

  a_wgt_avail: assert property (@(posedge clk) disable iff (!rst)
    in_wgt_avail == (wgt_depth < distribute_pkg::fifo_depth - 1))
    else begin
      errors++;
      $display("FAILED %s wgt_avail expected %b actual %b", test_name,
               $sampled(wgt_depth) < 3, $sampled(in_wgt_avail));
    end

  // weights only on reads 1, 1+reads, 1+2*reads and so on
  a_wgt_first: assert property (@(posedge clk) disable iff (!rst)
    in_wgt_out_valid == (in_act_out_valid && (in_seen % in_reads_cfg == 0)))
    else begin
      errors++;
      $display("FAILED %s wgt_out_valid expected %b actual %b", test_name,
               $sampled(in_act_out_valid) && ($sampled(in_seen) % in_reads_cfg == 0),
               $sampled(in_wgt_out_valid));
    end

  a_in_blocked: assert property (@(posedge clk) disable iff (!rst)
    (!in_busy || !(&in_act_out_avail) ||
     ((in_seen % in_reads_cfg == 0) && !in_wgt_out_avail)) |-> !in_act_out_valid)
    else begin
      errors++;
      $display("%s: act_out_valid high while idle or a downstream avail was low", test_name);
    end

  a_out_blocked: assert property (@(posedge clk) disable iff (!rst)
    (!out_busy || !(&out_res_out_avail)) |-> !out_res_out_valid)
    else begin
      errors++;
      $display("%s: res_out_valid high while idle or a downstream avail was low", test_name);
    end

  a_in_count: assert property (@(posedge clk) disable iff (!rst)
    $fell(in_busy) |-> in_seen == in_total)
    else begin
      errors++;
      $display("FAILED %s in read count expected %0d actual %0d", test_name,
               $sampled(in_total), $sampled(in_seen));
    end

  a_out_count: assert property (@(posedge clk) disable iff (!rst)
    $fell(out_busy) |-> out_seen == out_total)
    else begin
      errors++;
      $display("FAILED %s out read count expected %0d actual %0d", test_name,
               $sampled(out_total), $sampled(out_seen));
    end

  // all dut inputs for the coming cycle, valid only where avail is high
  task automatic drive_inputs();
    for (int i = 0; i < distribute_pkg::num_lanes; i++) begin
      in_act_valid[i]      = act_mask[i] & in_act_avail[i] & ($urandom_range(3) != 0);
      in_act_data[i]       = $urandom;
      out_res_valid[i]     = res_mask[i] & out_res_avail[i] & ($urandom_range(3) != 0);
      out_res_data[i]      = $urandom;
      in_act_out_avail[i]  = !rand_in_avail || ($urandom_range(3) != 0);
      out_res_out_avail[i] = !rand_out_avail || ($urandom_range(3) != 0);
    end
    in_wgt_valid     = wgt_feed & in_wgt_avail & ($urandom_range(3) != 0);
    in_wgt_data      = $urandom;
    in_wgt_out_avail = !rand_in_avail || ($urandom_range(3) != 0);
    in_configure     = 1'b0;  // pulses last one cycle
    out_configure    = 1'b0;
    chk_reset        = 1'b0;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
    drive_inputs();
  endtask

  task automatic configure_in(input int iters, input int reads);
    in_cfg.num_iters = 16'(iters);
    in_cfg.num_reads = 16'(reads);
    in_configure     = 1'b1;
    step();
  endtask

  task automatic configure_out(input int iters, input int reads);
    out_cfg.num_iters = 16'(iters);
    out_cfg.num_reads = 16'(reads);
    out_configure     = 1'b1;
    step();
  endtask

  function automatic bit cond_met(input wait_cond_e cond);
    case (cond)
      until_in_idle:    return !in_busy;
      until_out_idle:   return !out_busy;
      until_lane0_full: return !in_act_avail[0];
      until_lanes_full: return in_act_avail[3:1] == 3'b000;
      default:          return !in_wgt_avail;
    endcase
  endfunction

  task automatic finish_run();
    $display("in reads %0d, out reads %0d, errors %0d", in_reads_all, out_reads_all, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic wait_until(input wait_cond_e cond, input int limit);
    int cycles;
    cycles = 0;
    while (!cond_met(cond) && cycles < limit) begin
      step();
      cycles++;
    end
    if (!cond_met(cond)) begin
      errors++;
      $display("%s: gave up after %0d cycles waiting for %s", test_name, limit, cond.name());
      finish_run();
    end
  endtask

  initial begin
    void'($urandom(32'hf0c1));
    errors         = 0;
    test_name      = "reset";
    act_mask       = '0;
    res_mask       = '0;
    wgt_feed       = 1'b0;
    rand_in_avail  = 1'b0;
    rand_out_avail = 1'b0;
    in_cfg         = '0;
    out_cfg        = '0;
    drive_inputs();
    rst = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst       = 1'b1;
    chk_reset = 1'b1;
    step();

    // lane 0 from empty, then the rest and the weights, then drain
    test_name = "fifo_fill";
    act_mask  = 4'b0001;
    wait_until(until_lane0_full, 50);
    act_mask = '0;
    assert (act_q[0].size() == distribute_pkg::fifo_depth - 1) else begin
      errors++;
      $display("FAILED %s accepted words expected %0d actual %0d", test_name,
               distribute_pkg::fifo_depth - 1, act_q[0].size());
    end
    act_mask = 4'b1110;
    wait_until(until_lanes_full, 50);
    act_mask = '0;
    wgt_feed = 1'b1;
    wait_until(until_wgt_full, 50);
    wgt_feed = 1'b0;
    configure_in(1, distribute_pkg::fifo_depth - 1);
    wait_until(until_in_idle, 200);
    for (int i = 0; i < distribute_pkg::num_lanes; i++) begin
      assert (act_q[i].size() == 0) else begin
        errors++;
        $display("%s: lane %0d still holds %0d words after the drain", test_name, i,
                 act_q[i].size());
      end
    end

    test_name = "in_order";  // ends with leftovers still queued
    act_mask  = '1;
    wgt_feed  = 1'b1;
    configure_in(3, 4);
    wait_until(until_in_idle, 1000);
    act_mask = '0;
    wgt_feed = 1'b0;

    test_name     = "backpressure";
    rand_in_avail = 1'b1;
    act_mask      = '1;
    wgt_feed      = 1'b1;
    configure_in(3, 3);
    wait_until(until_in_idle, 2000);
    act_mask      = '0;
    wgt_feed      = 1'b0;
    rand_in_avail = 1'b0;

    test_name      = "out_forward";
    rand_out_avail = 1'b1;
    res_mask       = '1;
    configure_out(2, 3);
    wait_until(until_out_idle, 1000);
    res_mask       = '0;
    rand_out_avail = 1'b0;
    step();
    step();
    finish_run();
  end

endmodule

// ==== flist.f ====
src/distribute_pkg.sv
src/lane_fifo.sv
src/read_sequencer.sv
src/distribute_in.sv
src/distribute_out.sv
src/distribute_top.sv
bench/tb_distribute_top.sv
